//--- design/amem_pkg.sv
// amem package
// data word and ALU operation codes shared by the A-memory datapath.

`default_nettype none

package amem_pkg;

   localparam int word_w = 32;
   localparam int op_w = 3;

   // one A-memory word, also the ALU result.
   typedef logic [word_w-1:0] word_t;

   // micro-op operation field.
   typedef logic [op_w-1:0] alu_op_t;

   localparam alu_op_t op_add    = 3'd0;   // a + b, wraps.
   localparam alu_op_t op_sub    = 3'd1;   // a - b, wraps.
   localparam alu_op_t op_and    = 3'd2;
   localparam alu_op_t op_or     = 3'd3;
   localparam alu_op_t op_xor    = 3'd4;
   localparam alu_op_t op_pass_a = 3'd5;

   // codes 6 and 7 are unused and give zero.

endpackage

`default_nettype wire

//--- design/amem_dpram.sv
// A-memory scratchpad RAM
// two registered read ports and two write ports, port a wins a write clash.

`timescale 1ns/1ps
`default_nettype none

module amem_dpram
   import amem_pkg::*;
#(
   parameter int ADDR_W = 10
)
(
   input  wire              clk_a,
   input  wire              reset,

   // operand reads.
   input  wire [ADDR_W-1:0] rd_addr_a,
   input  wire              rden_a,
   input  wire [ADDR_W-1:0] rd_addr_b,
   input  wire              rden_b,

   // writeback from the ALU.
   input  wire [ADDR_W-1:0] wr_addr_a,
   input  wire              wren_a,
   input  wire word_t       data_a,

   // host preload.
   input  wire [ADDR_W-1:0] wr_addr_b,
   input  wire              wren_b,
   input  wire word_t       data_b,

   output word_t            q_a,
   output word_t            q_b
);

   localparam int ram_size = 1 << ADDR_W;

   word_t ram [0:ram_size-1];

   // only one write per edge, host write dropped on a clash.
   always_ff @(posedge clk_a)
   begin
      if (wren_a)
         ram[wr_addr_a] <= data_a;
      else if (wren_b)
         ram[wr_addr_b] <= data_b;
   end

   // a read at the write edge sees the old word.
   always_ff @(posedge clk_a)
   begin
      if (reset)
         q_a <= '0;
      else if (rden_a)
         q_a <= ram[rd_addr_a];
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
         q_b <= '0;
      else if (rden_b)
         q_b <= ram[rd_addr_b];
   end

endmodule

`default_nettype wire

//--- design/uop_fetch.sv
// micro-op fetch stage
// latches an issued micro-op, starts both operand reads and carries the
// op fields along so they line up with the RAM read data.

`timescale 1ns/1ps
`default_nettype none

module uop_fetch
   import amem_pkg::*;
#(
   parameter int ADDR_W = 10
)
(
   input  wire                    clk_a,
   input  wire                    reset,

   input  wire                    uop_valid,
   input  wire alu_op_t           uop_op,
   input  wire [ADDR_W-1:0]       uop_a_addr,
   input  wire [ADDR_W-1:0]       uop_b_addr,
   input  wire [ADDR_W-1:0]       uop_dest,

   output logic [ADDR_W-1:0]      rd_addr_a,
   output logic [ADDR_W-1:0]      rd_addr_b,
   output logic                   rden_a,
   output logic                   rden_b,

   output logic                   op_valid,
   output alu_op_t                op_code,
   output logic [ADDR_W-1:0]      op_dest,
   output logic [ADDR_W-1:0]      op_a_addr,
   output logic [ADDR_W-1:0]      op_b_addr
);

   logic              s1_valid;
   alu_op_t           s1_op;
   logic [ADDR_W-1:0] s1_dest;

   // both reads go out together.
   assign rden_a = s1_valid;
   assign rden_b = s1_valid;

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         s1_valid <= 1'b0;
         op_valid <= 1'b0;
      end
      else
      begin
         s1_valid <= uop_valid;
         op_valid <= s1_valid;   // lines up with q_a/q_b.
      end
   end

   // stage 1, issue capture.
   always_ff @(posedge clk_a)
   begin
      if (uop_valid)
      begin
         rd_addr_a <= uop_a_addr;
         rd_addr_b <= uop_b_addr;
         s1_op     <= uop_op;
         s1_dest   <= uop_dest;
      end
   end

   // stage 2, waits out the RAM read.
   always_ff @(posedge clk_a)
   begin
      if (s1_valid)
      begin
         op_code   <= s1_op;
         op_dest   <= s1_dest;
         op_a_addr <= rd_addr_a;
         op_b_addr <= rd_addr_b;
      end
   end

endmodule

`default_nettype wire

//--- design/alu_writeback.sv
// ALU and writeback stage
// forwards results not yet in the RAM, applies the micro-op and writes
// the result back through RAM port a one cycle after it is presented.

`timescale 1ns/1ps
`default_nettype none

module alu_writeback
   import amem_pkg::*;
#(
   parameter int ADDR_W = 10
)
(
   input  wire                    clk_a,
   input  wire                    reset,

   input  wire                    op_valid,
   input  wire alu_op_t           op_code,
   input  wire [ADDR_W-1:0]       op_dest,
   input  wire [ADDR_W-1:0]       op_a_addr,
   input  wire [ADDR_W-1:0]       op_b_addr,
   input  wire word_t             q_a,
   input  wire word_t             q_b,

   output logic [ADDR_W-1:0]      wr_addr_a,
   output word_t                  data_a,
   output logic                   wren_a,

   output word_t                  result,
   output logic                   result_valid,
   output logic [ADDR_W-1:0]      result_dest
);

   // result just written, still racing the operand read.
   logic              w2_valid;
   logic [ADDR_W-1:0] w2_addr;
   word_t             w2_data;

   word_t             opnd_a;
   word_t             opnd_b;
   word_t             alu_out;

   // newest match wins.
   function automatic word_t forward(input logic [ADDR_W-1:0] addr,
                                     input word_t ram_word);
      word_t w;
      w = ram_word;
      if (w2_valid && w2_addr == addr)
         w = w2_data;
      if (wren_a && wr_addr_a == addr)
         w = data_a;
      if (result_valid && result_dest == addr)
         w = result;
      return w;
   endfunction

   always_comb
   begin
      opnd_a = forward(op_a_addr, q_a);
      opnd_b = forward(op_b_addr, q_b);
   end

   always_comb
   begin
      case (op_code)
         op_add:    alu_out = opnd_a + opnd_b;
         op_sub:    alu_out = opnd_a - opnd_b;
         op_and:    alu_out = opnd_a & opnd_b;
         op_or:     alu_out = opnd_a | opnd_b;
         op_xor:    alu_out = opnd_a ^ opnd_b;
         op_pass_a: alu_out = opnd_a;
         default:   alu_out = '0;   // unused codes.
      endcase
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         result_valid <= 1'b0;
         result       <= '0;
         wren_a       <= 1'b0;
         w2_valid     <= 1'b0;
      end
      else
      begin
         result_valid <= op_valid;
         wren_a       <= result_valid;   // write one cycle behind.
         w2_valid     <= wren_a;
         if (op_valid)
            result <= alu_out;
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (op_valid)
         result_dest <= op_dest;
      data_a    <= result;
      wr_addr_a <= result_dest;
      w2_data   <= data_a;
      w2_addr   <= wr_addr_a;
   end

endmodule

`default_nettype wire

//--- design/amem_datapath.sv
// A-memory datapath top
// micro-op fetch, scratchpad RAM and ALU writeback, plus the host load port.

`timescale 1ns/1ps
`default_nettype none

module amem_datapath
   import amem_pkg::*;
#(
   parameter int ADDR_W = 10
)
(
   input  wire                    clk_a,
   input  wire                    reset,

   input  wire                    uop_valid,
   input  wire alu_op_t           uop_op,
   input  wire [ADDR_W-1:0]       uop_a_addr,
   input  wire [ADDR_W-1:0]       uop_b_addr,
   input  wire [ADDR_W-1:0]       uop_dest,

   input  wire                    load_valid,
   input  wire [ADDR_W-1:0]       load_addr,
   input  wire word_t             load_data,

   output word_t                  result,
   output logic                   result_valid,
   output logic [ADDR_W-1:0]      result_dest
);

   logic [ADDR_W-1:0] rd_addr_a;
   logic [ADDR_W-1:0] rd_addr_b;
   logic              rden_a;
   logic              rden_b;

   logic              op_valid;
   alu_op_t           op_code;
   logic [ADDR_W-1:0] op_dest;
   logic [ADDR_W-1:0] op_a_addr;
   logic [ADDR_W-1:0] op_b_addr;

   word_t             q_a;
   word_t             q_b;

   logic [ADDR_W-1:0] wr_addr_a;
   word_t             data_a;
   logic              wren_a;

   uop_fetch #(.ADDR_W(ADDR_W)) u_fetch (
      .clk_a      (clk_a),
      .reset      (reset),
      .uop_valid  (uop_valid),
      .uop_op     (uop_op),
      .uop_a_addr (uop_a_addr),
      .uop_b_addr (uop_b_addr),
      .uop_dest   (uop_dest),
      .rd_addr_a  (rd_addr_a),
      .rd_addr_b  (rd_addr_b),
      .rden_a     (rden_a),
      .rden_b     (rden_b),
      .op_valid   (op_valid),
      .op_code    (op_code),
      .op_dest    (op_dest),
      .op_a_addr  (op_a_addr),
      .op_b_addr  (op_b_addr)
   );

   // host load rides on port b's write side.
   amem_dpram #(.ADDR_W(ADDR_W)) u_ram (
      .clk_a     (clk_a),
      .reset     (reset),
      .rd_addr_a (rd_addr_a),
      .rden_a    (rden_a),
      .rd_addr_b (rd_addr_b),
      .rden_b    (rden_b),
      .wr_addr_a (wr_addr_a),
      .wren_a    (wren_a),
      .data_a    (data_a),
      .wr_addr_b (load_addr),
      .wren_b    (load_valid),
      .data_b    (load_data),
      .q_a       (q_a),
      .q_b       (q_b)
   );

   alu_writeback #(.ADDR_W(ADDR_W)) u_alu (
      .clk_a        (clk_a),
      .reset        (reset),
      .op_valid     (op_valid),
      .op_code      (op_code),
      .op_dest      (op_dest),
      .op_a_addr    (op_a_addr),
      .op_b_addr    (op_b_addr),
      .q_a          (q_a),
      .q_b          (q_b),
      .wr_addr_a    (wr_addr_a),
      .data_a       (data_a),
      .wren_a       (wren_a),
      .result       (result),
      .result_valid (result_valid),
      .result_dest  (result_dest)
   );

endmodule

`default_nettype wire

//--- tests/amem_assertions.sv
// bound checks for the A-memory datapath
// result and writeback timing, and the port-a write priority of the RAM.

`timescale 1ns/1ps
`default_nettype none

module amem_assertions
   import amem_pkg::*;
#(
   parameter int ADDR_W = 10
)
(
   input  wire              clk_a,
   input  wire              reset,
   input  wire              uop_valid,
   input  wire              result_valid,
   input  wire              wren_a,
   input  wire [ADDR_W-1:0] wr_addr_a,
   input  wire word_t       data_a,
   input  wire              wren_b,
   input  wire [ADDR_W-1:0] wr_addr_b,
   input  wire word_t       ram [0:(1<<ADDR_W)-1]
);

   int unsigned fail_count;

   initial
      fail_count = 0;

   // writeback one edge behind the result.
   a_wren_timing: assert property (@(posedge clk_a) disable iff (reset)
      wren_a == $past(result_valid))
   else
   begin
      $error("wren_a does not trail result_valid by one cycle");
      fail_count++;
   end

   a_result_latency: assert property (@(posedge clk_a) disable iff (reset)
      result_valid == $past(uop_valid, 3))   // fixed three-cycle latency.
   else
   begin
      $error("result_valid does not follow uop_valid by three cycles");
      fail_count++;
   end

   a_port_a_wins: assert property (@(posedge clk_a) disable iff (reset)
      wren_a && wren_b |=> ram[$past(wr_addr_a)] == $past(data_a))
   else
   begin
      $error("port a write lost in a write clash");
      fail_count++;
   end

   // losing host write leaves its word alone.
   a_host_dropped: assert property (@(posedge clk_a) disable iff (reset)
      wren_a && wren_b && wr_addr_a != wr_addr_b |=>
         ram[$past(wr_addr_b)] == $past(ram[wr_addr_b]))
   else
   begin
      $error("host write landed under a port a write");
      fail_count++;
   end

endmodule

`default_nettype wire

//--- tests/tb_amem_datapath.sv
// testbench for the A-memory datapath
// preloads the RAM, issues a table of micro-ops and checks every result.

`timescale 1ns/1ps
`default_nettype none

module tb_amem_datapath
   import amem_pkg::*;
();

   localparam int addr_w       = 10;
   localparam int clk_period   = 100;
   localparam int reset_cycles = 3;
   localparam int load_count   = 16;

   logic              clk_a;
   logic              reset;
   logic              uop_valid;
   alu_op_t           uop_op;
   logic [addr_w-1:0] uop_a_addr;
   logic [addr_w-1:0] uop_b_addr;
   logic [addr_w-1:0] uop_dest;
   logic              load_valid;
   logic [addr_w-1:0] load_addr;
   word_t             load_data;
   word_t             result;
   logic              result_valid;
   logic [addr_w-1:0] result_dest;

   // micro-op table, one entry per cycle.
   string             row_name[$];
   bit                row_issue[$];
   alu_op_t           row_op[$];
   logic [addr_w-1:0] row_a[$];
   logic [addr_w-1:0] row_b[$];
   logic [addr_w-1:0] row_dest[$];
   bit                row_load[$];
   logic [addr_w-1:0] row_load_addr[$];
   word_t             row_load_data[$];

   // results in flight, oldest first.
   word_t             exp_result_q[$];
   logic [addr_w-1:0] exp_dest_q[$];
   string             exp_name_q[$];
   int                exp_edge_q[$];

   word_t             model [0:(1<<addr_w)-1];
   logic [31:0]       rng_state;
   int                cycle;
   bit                table_built;

   amem_datapath #(.ADDR_W(addr_w)) uut (
      .clk_a        (clk_a),
      .reset        (reset),
      .uop_valid    (uop_valid),
      .uop_op       (uop_op),
      .uop_a_addr   (uop_a_addr),
      .uop_b_addr   (uop_b_addr),
      .uop_dest     (uop_dest),
      .load_valid   (load_valid),
      .load_addr    (load_addr),
      .load_data    (load_data),
      .result       (result),
      .result_valid (result_valid),
      .result_dest  (result_dest)
   );

   bind amem_datapath amem_assertions #(.ADDR_W(ADDR_W)) u_assert (
      .clk_a        (clk_a),
      .reset        (reset),
      .uop_valid    (uop_valid),
      .result_valid (result_valid),
      .wren_a       (wren_a),
      .wr_addr_a    (wr_addr_a),
      .data_a       (data_a),
      .wren_b       (load_valid),
      .wr_addr_b    (load_addr),
      .ram          (u_ram.ram)
   );

   always #(clk_period/2) clk_a = ~clk_a;

   always @(posedge clk_a)
      cycle <= cycle + 1;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic word_t expected_alu(input alu_op_t op, input word_t a, input word_t b);
      case (op)
         op_add:    return a + b;
         op_sub:    return a - b;
         op_and:    return a & b;
         op_or:     return a | b;
         op_xor:    return a ^ b;
         op_pass_a: return a;
         default:   return '0;
      endcase
   endfunction

   task automatic abort_run();
      $display("*** TEST FAILED ***");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check_equal(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual)
      begin
         $display("ERROR %s: expected %h, actual %h", name, expected, actual);
         abort_run();
      end
   endtask

   task automatic add_row(input string name, input bit issue, input alu_op_t op,
                          input logic [addr_w-1:0] a, input logic [addr_w-1:0] b,
                          input logic [addr_w-1:0] dest, input bit load,
                          input logic [addr_w-1:0] l_addr, input word_t l_data);
      row_name.push_back(name);
      row_issue.push_back(issue);
      row_op.push_back(op);
      row_a.push_back(a);
      row_b.push_back(b);
      row_dest.push_back(dest);
      row_load.push_back(load);
      row_load_addr.push_back(l_addr);
      row_load_data.push_back(l_data);
   endtask

   task automatic add_op(input string name, input alu_op_t op, input logic [addr_w-1:0] a,
                         input logic [addr_w-1:0] b, input logic [addr_w-1:0] dest);
      add_row(name, 1'b1, op, a, b, dest, 1'b0, '0, '0);
   endtask

   task automatic add_idle();
      add_row("idle", 1'b0, op_add, '0, '0, '0, 1'b0, '0, '0);
   endtask

   task automatic build_table();
      add_op("add", op_add, 10'd0, 10'd1, 10'd16);
      add_op("sub", op_sub, 10'd2, 10'd3, 10'd17);
      add_op("and", op_and, 10'd4, 10'd5, 10'd18);
      add_op("or", op_or, 10'd6, 10'd7, 10'd19);
      add_op("xor", op_xor, 10'd8, 10'd9, 10'd20);
      add_op("unused_6", 3'd6, 10'd12, 10'd13, 10'd22);
      add_op("unused_7", 3'd7, 10'd14, 10'd15, 10'd23);
      add_op("pass_a", op_pass_a, 10'd10, 10'd11, 10'd21);
      add_op("fwd_dist1_a", op_add, 10'd21, 10'd0, 10'd24);
      add_op("fwd_dist1_b", op_sub, 10'd1, 10'd24, 10'd25);
      add_op("fwd_dist2", op_xor, 10'd24, 10'd25, 10'd26);
      add_op("fwd_dist3", op_add, 10'd24, 10'd25, 10'd27);
      add_op("fwd_self", op_add, 10'd27, 10'd27, 10'd27);
      add_op("fwd_mixed", op_add, 10'd27, 10'd26, 10'd28);
      add_idle();
      add_idle();
      add_idle();
      add_idle();
      add_op("readback", op_pass_a, 10'd16, 10'd0, 10'd29);
      add_op("readback_self", op_pass_a, 10'd27, 10'd0, 10'd30);
      add_op("late_sub", op_sub, 10'd16, 10'd17, 10'd31);
      add_op("late_xor", op_xor, 10'd18, 10'd19, 10'd32);
      // both loads land under a writeback.
      add_row("load_clash_op", 1'b1, op_and, 10'd20, 10'd21, 10'd33,
              1'b1, 10'd29, 32'hdead_beef);
      add_row("load_clash_idle", 1'b0, op_add, '0, '0, '0, 1'b1, 10'd5, 32'h1234_5678);
      add_idle();
      add_idle();
      add_op("load_dropped", op_pass_a, 10'd5, 10'd0, 10'd34);
      add_op("load_lost_to_a", op_pass_a, 10'd29, 10'd0, 10'd35);
   endtask

   task automatic preload_ram();
      int i;
      for (i = 0; i < load_count; i++)
      begin
         rng_state = xorshift(rng_state);
         @(posedge clk_a);
         load_valid <= 1'b1;
         load_addr  <= addr_w'(i);
         load_data  <= rng_state;
         model[i]   = rng_state;
      end
   endtask

   task automatic run_table();
      int    i;
      word_t res;
      for (i = 0; i < row_name.size(); i++)
      begin
         @(posedge clk_a);
         uop_valid  <= row_issue[i];
         uop_op     <= row_op[i];
         uop_a_addr <= row_a[i];
         uop_b_addr <= row_b[i];
         uop_dest   <= row_dest[i];
         load_valid <= row_load[i];
         load_addr  <= row_load_addr[i];
         load_data  <= row_load_data[i];
         // writeback of an op trails its issue by four edges and blocks the load.
         if (row_load[i] && !(i >= 4 && row_issue[i-4]))
            model[row_load_addr[i]] = row_load_data[i];
         if (row_issue[i])
         begin
            res = expected_alu(row_op[i], model[row_a[i]], model[row_b[i]]);
            model[row_dest[i]] = res;
            exp_result_q.push_back(res);
            exp_dest_q.push_back(row_dest[i]);
            exp_name_q.push_back(row_name[i]);
            exp_edge_q.push_back(cycle + 1);   // edge number of this issue.
         end
      end
      @(posedge clk_a);
      uop_valid  <= 1'b0;
      load_valid <= 1'b0;
   endtask

   // results are sampled half a cycle after the edge.
   always @(negedge clk_a)
   begin
      if (uut.u_assert.fail_count != 0)
      begin
         $display("a bound assertion failed, see the error above");
         abort_run();
      end
      else if (!reset && result_valid === 1'b1)
      begin
         if (exp_result_q.size() == 0)
         begin
            $display("result_valid went high with no micro-op in flight");
            abort_run();
         end
         else
         begin
            check_equal(exp_name_q[0], exp_result_q[0], result);
            check_equal({exp_name_q[0], "_dest"}, 32'(exp_dest_q[0]), 32'(result_dest));
            check_equal({exp_name_q[0], "_latency"}, 32'd3, 32'(cycle - exp_edge_q[0]));
            void'(exp_result_q.pop_front());
            void'(exp_dest_q.pop_front());
            void'(exp_name_q.pop_front());
            void'(exp_edge_q.pop_front());
         end
      end
   end

   initial
   begin
      int limit;
      wait (table_built);
      limit = reset_cycles + load_count + row_name.size() + 20;
      #(limit * clk_period);
      $display("timeout: results still missing after %0d cycles", limit);
      abort_run();
   end

   initial
   begin
      clk_a       = 1'b0;
      reset       = 1'b1;
      uop_valid   = 1'b0;
      uop_op      = op_add;
      uop_a_addr  = '0;
      uop_b_addr  = '0;
      uop_dest    = '0;
      load_valid  = 1'b0;
      load_addr   = '0;
      load_data   = '0;
      cycle       = 0;
      rng_state   = 32'h701d;
      table_built = 1'b0;
      build_table();
      table_built = 1'b1;

      repeat (reset_cycles) @(posedge clk_a);
      reset <= 1'b0;
      @(negedge clk_a);
      check_equal("reset_result", '0, result);
      check_equal("reset_valid", '0, 32'(result_valid));

      preload_ram();
      run_table();
      while (exp_result_q.size() != 0)
         @(posedge clk_a);
      repeat (3) @(posedge clk_a);   // no stray results.
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

//--- src.f
design/amem_pkg.sv
design/amem_dpram.sv
design/uop_fetch.sv
design/alu_writeback.sv
design/amem_datapath.sv
tests/amem_assertions.sv
tests/tb_amem_datapath.sv

//--- Makefile
# Verilator build and run for the A-memory datapath testbench.

VERILATOR ?= verilator
TOP       ?= tb_amem_datapath
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	@$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -qF '*** TEST PASSED ***' $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
